/* build.f */
+incdir+.
id_pkg.sv
id_decoder.sv
id_pipe_reg.sv
id_stage.sv
tb_id.sv

/* id_decoder.sv */
// combinational decode of one RV32IM word into register and memory enables
// register fields are extracted for every word, legal or not
// DIV/DIVU/REM/REMU do not raise reg_we_o, their result is written back elsewhere
// SB/SH raise mem_re_o too, the memory does read-modify-write for partial stores
`timescale 1ns/1ps

module id_decoder (
    input  id_pkg::inst_t     inst_i,
    output logic              valid_o,
    output logic              reg1_re_o,
    output logic              reg2_re_o,
    output logic              reg_we_o,
    output logic              mem_re_o,
    output logic              mem_we_o,
    output id_pkg::reg_addr_t rs1_o,
    output id_pkg::reg_addr_t rs2_o,
    output id_pkg::reg_addr_t rd_o
);

    import id_pkg::*;

    opcode_e opcode;
    funct3_t funct3;
    funct7_t funct7;

    assign opcode = opcode_e'(inst_i[6:0]);
    assign funct3 = inst_i[14:12];
    assign funct7 = inst_i[31:25];

    assign rd_o  = inst_i[11:7];
    assign rs1_o = inst_i[19:15];
    assign rs2_o = inst_i[24:20];

    always_comb begin
        valid_o   = 1'b0;   // illegal unless matched below
        reg1_re_o = 1'b0;
        reg2_re_o = 1'b0;
        reg_we_o  = 1'b0;
        mem_re_o  = 1'b0;
        mem_we_o  = 1'b0;

        case (opcode)
            OP_IMM: begin
                case (funct3)
                    F3_ADDI, F3_SLLI, F3_SLTI, F3_SLTIU,
                    F3_XORI, F3_SRI, F3_ORI, F3_ANDI: begin
                        valid_o   = 1'b1;
                        reg1_re_o = 1'b1;
                        reg_we_o  = 1'b1;
                    end
                endcase
            end
            OP_REG: begin
                if (funct7 == F7_BASE || funct7 == F7_ALT) begin
                    case (funct3)
                        F3_ADD_SUB, F3_SLL, F3_SLT, F3_SLTU,
                        F3_XOR, F3_SR, F3_OR, F3_AND: begin
                            valid_o   = 1'b1;
                            reg1_re_o = 1'b1;
                            reg2_re_o = 1'b1;
                            reg_we_o  = 1'b1;
                        end
                    endcase
                end else if (funct7 == F7_MULDIV) begin
                    case (funct3)
                        F3_MUL, F3_MULH, F3_MULHSU, F3_MULHU: begin
                            valid_o   = 1'b1;
                            reg1_re_o = 1'b1;
                            reg2_re_o = 1'b1;
                            reg_we_o  = 1'b1;
                        end
                        F3_DIV, F3_DIVU, F3_REM, F3_REMU: begin
                            valid_o   = 1'b1;   // divider owns writeback
                            reg1_re_o = 1'b1;
                            reg2_re_o = 1'b1;
                        end
                    endcase
                end
            end
            OP_LOAD: begin
                case (funct3)
                    F3_LB, F3_LH, F3_LW, F3_LBU, F3_LHU: begin
                        valid_o   = 1'b1;
                        reg1_re_o = 1'b1;
                        reg_we_o  = 1'b1;
                        mem_re_o  = 1'b1;
                    end
                    default: begin
                        valid_o = 1'b0;
                    end
                endcase
            end
            OP_STORE: begin
                case (funct3)
                    F3_SB, F3_SH: begin
                        valid_o   = 1'b1;
                        reg1_re_o = 1'b1;
                        reg2_re_o = 1'b1;
                        mem_re_o  = 1'b1;   // read-modify-write
                        mem_we_o  = 1'b1;
                    end
                    F3_SW: begin
                        valid_o   = 1'b1;
                        reg1_re_o = 1'b1;
                        reg2_re_o = 1'b1;
                        mem_we_o  = 1'b1;
                    end
                    default: begin
                        valid_o = 1'b0;
                    end
                endcase
            end
            OP_BRANCH: begin
                case (funct3)
                    F3_BEQ, F3_BNE, F3_BLT, F3_BGE, F3_BLTU, F3_BGEU: begin
                        valid_o   = 1'b1;
                        reg1_re_o = 1'b1;
                        reg2_re_o = 1'b1;
                    end
                    default: begin
                        valid_o = 1'b0;
                    end
                endcase
            end
            OP_JAL, OP_LUI, OP_AUIPC: begin
                valid_o  = 1'b1;
                reg_we_o = 1'b1;
            end
            OP_JALR: begin
                valid_o   = 1'b1;
                reg1_re_o = 1'b1;
                reg_we_o  = 1'b1;
            end
            OP_NOP, OP_FENCE: begin
                valid_o = 1'b1;   // no register or memory side effects
            end
            default: begin
                valid_o = 1'b0;
            end
        endcase
    end

    // an illegal word must not reach the register file or memory
    always_comb begin
        if (!valid_o) begin
            assert (!(reg1_re_o || reg2_re_o || reg_we_o || mem_re_o || mem_we_o))
                else $error("illegal instruction decoded with an enable high");
        end
    end

endmodule

/* id_defines.svh */
// widths and the core's NOP word for the decode stage
// the NOP word is not a standard RISC-V encoding, opcode 7'b0000001
// changing ID_REG_AW alone does not move the rs/rd fields in the word
`ifndef ID_DEFINES_SVH
`define ID_DEFINES_SVH

// instruction word width
`define ID_XLEN 32

// instruction address width
`define ID_ADDR_W 32

// register file index width
`define ID_REG_AW 5

// bubble and core NOP
`define ID_INST_NOP 32'h00000001

`endif

/* id_pipe_reg.sv */
// decode to execute register with bubble insertion
// bubble priority is halt, then jump on a non-NOP word, then hold
// a bubble still loads the address and register fields, only the enables drop
// upstream must keep its own instruction while hold is high
`timescale 1ns/1ps
`include "id_defines.svh"

module id_pipe_reg (
    input  logic                clk,
    input  logic                reset_i,
    input  id_pkg::inst_t       inst_i,
    input  id_pkg::inst_addr_t  inst_addr_i,
    input  logic                jump_flag_i,
    input  logic                hold_flag_i,
    input  logic                halt_flag_i,
    input  logic                dec_valid_i,
    input  logic                dec_reg1_re_i,
    input  logic                dec_reg2_re_i,
    input  logic                dec_reg_we_i,
    input  logic                dec_mem_re_i,
    input  logic                dec_mem_we_i,
    input  id_pkg::reg_addr_t   dec_rs1_i,
    input  id_pkg::reg_addr_t   dec_rs2_i,
    input  id_pkg::reg_addr_t   dec_rd_i,
    output logic                reg1_re_o,
    output id_pkg::reg_addr_t   reg1_raddr_o,
    output logic                reg2_re_o,
    output id_pkg::reg_addr_t   reg2_raddr_o,
    output logic                reg_we_o,
    output id_pkg::reg_addr_t   reg_waddr_o,
    output id_pkg::inst_t       inst_o,
    output id_pkg::inst_addr_t  inst_addr_o,
    output logic                inst_valid_o,
    output logic                mem_re_o,
    output logic                mem_we_o
);

    logic bubble;

    always_comb begin
        if (halt_flag_i) begin
            bubble = 1'b1;
        end else if (jump_flag_i && inst_i != `ID_INST_NOP) begin
            bubble = 1'b1;   // flush wrong-path word
        end else if (hold_flag_i) begin
            bubble = 1'b1;
        end else begin
            bubble = 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            inst_o       <= '0;
            inst_addr_o  <= '0;
            inst_valid_o <= 1'b0;
            reg1_re_o    <= 1'b0;
            reg2_re_o    <= 1'b0;
            reg_we_o     <= 1'b0;
            mem_re_o     <= 1'b0;
            mem_we_o     <= 1'b0;
            reg1_raddr_o <= '0;
            reg2_raddr_o <= '0;
            reg_waddr_o  <= '0;
        end else begin
            inst_addr_o  <= inst_addr_i;
            reg1_raddr_o <= dec_rs1_i;
            reg2_raddr_o <= dec_rs2_i;
            reg_waddr_o  <= dec_rd_i;
            if (bubble) begin
                inst_o       <= `ID_INST_NOP;
                inst_valid_o <= 1'b1;   // a bubble is a valid NOP
                reg1_re_o    <= 1'b0;
                reg2_re_o    <= 1'b0;
                reg_we_o     <= 1'b0;
                mem_re_o     <= 1'b0;
                mem_we_o     <= 1'b0;
            end else begin
                inst_o       <= inst_i;
                inst_valid_o <= dec_valid_i;
                reg1_re_o    <= dec_reg1_re_i;
                reg2_re_o    <= dec_reg2_re_i;
                reg_we_o     <= dec_reg_we_i;
                mem_re_o     <= dec_mem_re_i;
                mem_we_o     <= dec_mem_we_i;
            end
        end
    end

    // stores never write a register, whatever the decoder produced
    a_no_store_writeback: assert property (
        @(posedge clk) disable iff (reset_i) !(mem_we_o && reg_we_o)
    ) else $error("mem_we_o and reg_we_o high together");

    a_reset_clears: assert property (
        @(posedge clk) reset_i |=> !(inst_valid_o || reg1_re_o || reg2_re_o ||
                                     reg_we_o || mem_re_o || mem_we_o)
    ) else $error("enable high in the cycle after reset");

endmodule

/* id_pkg.sv */
// types and encodings shared by the decode stage and its testbench
// opcode values are RV32I plus the core's private NOP opcode
// funct3 names follow the RV32IM spec, SRI/SR cover both logic and arith shifts
`include "id_defines.svh"

package id_pkg;

    typedef logic [`ID_XLEN-1:0]   inst_t;
    typedef logic [`ID_ADDR_W-1:0] inst_addr_t;
    typedef logic [`ID_REG_AW-1:0] reg_addr_t;
    typedef logic [2:0]            funct3_t;
    typedef logic [6:0]            funct7_t;

    typedef enum logic [6:0] {
        OP_IMM    = 7'b0010011,
        OP_REG    = 7'b0110011,   // base and M extension
        OP_LOAD   = 7'b0000011,
        OP_STORE  = 7'b0100011,
        OP_BRANCH = 7'b1100011,
        OP_JAL    = 7'b1101111,
        OP_JALR   = 7'b1100111,
        OP_LUI    = 7'b0110111,
        OP_AUIPC  = 7'b0010111,
        OP_NOP    = 7'b0000001,   // core specific
        OP_FENCE  = 7'b0001111
    } opcode_e;

    // I-type ALU
    localparam funct3_t F3_ADDI  = 3'b000;
    localparam funct3_t F3_SLLI  = 3'b001;
    localparam funct3_t F3_SLTI  = 3'b010;
    localparam funct3_t F3_SLTIU = 3'b011;
    localparam funct3_t F3_XORI  = 3'b100;
    localparam funct3_t F3_SRI   = 3'b101;   // srli/srai
    localparam funct3_t F3_ORI   = 3'b110;
    localparam funct3_t F3_ANDI  = 3'b111;

    // R-type base
    localparam funct3_t F3_ADD_SUB = 3'b000;
    localparam funct3_t F3_SLL     = 3'b001;
    localparam funct3_t F3_SLT     = 3'b010;
    localparam funct3_t F3_SLTU    = 3'b011;
    localparam funct3_t F3_XOR     = 3'b100;
    localparam funct3_t F3_SR      = 3'b101;   // srl/sra
    localparam funct3_t F3_OR      = 3'b110;
    localparam funct3_t F3_AND     = 3'b111;

    // R-type M extension
    localparam funct3_t F3_MUL    = 3'b000;
    localparam funct3_t F3_MULH   = 3'b001;
    localparam funct3_t F3_MULHSU = 3'b010;
    localparam funct3_t F3_MULHU  = 3'b011;
    localparam funct3_t F3_DIV    = 3'b100;
    localparam funct3_t F3_DIVU   = 3'b101;
    localparam funct3_t F3_REM    = 3'b110;
    localparam funct3_t F3_REMU   = 3'b111;

    // loads
    localparam funct3_t F3_LB  = 3'b000;
    localparam funct3_t F3_LH  = 3'b001;
    localparam funct3_t F3_LW  = 3'b010;
    localparam funct3_t F3_LBU = 3'b100;
    localparam funct3_t F3_LHU = 3'b101;

    // stores
    localparam funct3_t F3_SB = 3'b000;
    localparam funct3_t F3_SH = 3'b001;
    localparam funct3_t F3_SW = 3'b010;

    // branches
    localparam funct3_t F3_BEQ  = 3'b000;
    localparam funct3_t F3_BNE  = 3'b001;
    localparam funct3_t F3_BLT  = 3'b100;
    localparam funct3_t F3_BGE  = 3'b101;
    localparam funct3_t F3_BLTU = 3'b110;
    localparam funct3_t F3_BGEU = 3'b111;

    localparam funct7_t F7_BASE   = 7'b0000000;
    localparam funct7_t F7_ALT    = 7'b0100000;   // sub, sra
    localparam funct7_t F7_MULDIV = 7'b0000001;

endpackage

/* id_stage.sv */
// instruction decode stage, one cycle from inst_i to the registered outputs
// no handshake, one word per cycle, hold/jump/halt are the only flow control
// unknown encodings come out with inst_valid_o low and all enables low
`timescale 1ns/1ps

module id_stage (
    input  logic                clk,
    input  logic                reset_i,
    input  id_pkg::inst_t       inst_i,
    input  id_pkg::inst_addr_t  inst_addr_i,
    input  logic                jump_flag_i,    // from execute
    input  logic                hold_flag_i,    // from execute
    input  logic                halt_flag_i,    // from data memory
    output logic                reg1_re_o,
    output id_pkg::reg_addr_t   reg1_raddr_o,
    output logic                reg2_re_o,
    output id_pkg::reg_addr_t   reg2_raddr_o,
    output logic                reg_we_o,
    output id_pkg::reg_addr_t   reg_waddr_o,
    output id_pkg::inst_t       inst_o,
    output id_pkg::inst_addr_t  inst_addr_o,
    output logic                inst_valid_o,
    output logic                mem_re_o,
    output logic                mem_we_o
);

    import id_pkg::*;

    logic      dec_valid;
    logic      dec_reg1_re;
    logic      dec_reg2_re;
    logic      dec_reg_we;
    logic      dec_mem_re;
    logic      dec_mem_we;
    reg_addr_t dec_rs1;
    reg_addr_t dec_rs2;
    reg_addr_t dec_rd;

    id_decoder i_decoder (
        .inst_i    (inst_i),
        .valid_o   (dec_valid),
        .reg1_re_o (dec_reg1_re),
        .reg2_re_o (dec_reg2_re),
        .reg_we_o  (dec_reg_we),
        .mem_re_o  (dec_mem_re),
        .mem_we_o  (dec_mem_we),
        .rs1_o     (dec_rs1),
        .rs2_o     (dec_rs2),
        .rd_o      (dec_rd)
    );

    id_pipe_reg i_pipe_reg (
        .clk           (clk),
        .reset_i       (reset_i),
        .inst_i        (inst_i),
        .inst_addr_i   (inst_addr_i),
        .jump_flag_i   (jump_flag_i),
        .hold_flag_i   (hold_flag_i),
        .halt_flag_i   (halt_flag_i),
        .dec_valid_i   (dec_valid),
        .dec_reg1_re_i (dec_reg1_re),
        .dec_reg2_re_i (dec_reg2_re),
        .dec_reg_we_i  (dec_reg_we),
        .dec_mem_re_i  (dec_mem_re),
        .dec_mem_we_i  (dec_mem_we),
        .dec_rs1_i     (dec_rs1),
        .dec_rs2_i     (dec_rs2),
        .dec_rd_i      (dec_rd),
        .reg1_re_o     (reg1_re_o),
        .reg1_raddr_o  (reg1_raddr_o),
        .reg2_re_o     (reg2_re_o),
        .reg2_raddr_o  (reg2_raddr_o),
        .reg_we_o      (reg_we_o),
        .reg_waddr_o   (reg_waddr_o),
        .inst_o        (inst_o),
        .inst_addr_o   (inst_addr_o),
        .inst_valid_o  (inst_valid_o),
        .mem_re_o      (mem_re_o),
        .mem_we_o      (mem_we_o)
    );

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# Builds tb_id with Verilator, runs it and checks the log for the fail message.

cd "$(dirname "$0")" || exit 1

log_file=sim.log

verilator --binary --timing --assert --top-module tb_id -f build.f
build_status=$?
if [ $build_status -ne 0 ]; then
    echo "verilator build failed with status $build_status"
    exit 1
fi

./obj_dir/Vtb_id > "$log_file" 2>&1
sim_status=$?
cat "$log_file"

if grep -q "Something failed" "$log_file"; then
    echo "simulation FAILED, see $log_file"
    exit 1
fi

if [ $sim_status -ne 0 ]; then
    echo "simulator exited with status $sim_status"
    exit 1
fi

echo "simulation passed"
exit 0

/* tb_id_ref.svh */
// reference model and stimulus generators for the decode stage testbench
// included inside tb_id after the id_pkg import, not compiled on its own
// the model follows the decode table and the bubble priority of the stage
`ifndef TB_ID_REF_SVH
`define TB_ID_REF_SVH

typedef struct packed {
    inst_t      inst;
    inst_addr_t addr;
    logic       valid;
    logic       reg1_re;
    logic       reg2_re;
    logic       reg_we;
    logic       mem_re;
    logic       mem_we;
    reg_addr_t  rs1;
    reg_addr_t  rs2;
    reg_addr_t  rd;
} exp_t;

// expected outputs one cycle after inst/addr/flags are sampled
function automatic exp_t expect_out(input inst_t inst, input inst_addr_t addr,
                                    input logic jump, input logic hold,
                                    input logic halt);
    exp_t       e;
    logic [5:0] en;   // valid, reg1_re, reg2_re, reg_we, mem_re, mem_we
    logic [6:0] op;
    logic [2:0] f3;
    logic [6:0] f7;
    logic       bubble;
    op = inst[6:0];
    f3 = inst[14:12];
    f7 = inst[31:25];
    en = 6'b000000;
    case (op)
        OP_IMM: en = 6'b110100;
        OP_REG: begin
            if (f7 == F7_BASE || f7 == F7_ALT)
                en = 6'b111100;
            else if (f7 == F7_MULDIV)
                en = f3[2] ? 6'b111000 : 6'b111100;   // div/rem skip writeback
        end
        OP_LOAD: if (f3 inside {F3_LB, F3_LH, F3_LW, F3_LBU, F3_LHU}) en = 6'b110110;
        OP_STORE: begin
            if (f3 == F3_SB || f3 == F3_SH)
                en = 6'b111011;
            else if (f3 == F3_SW)
                en = 6'b111001;
        end
        OP_BRANCH: if (f3 != 3'b010 && f3 != 3'b011) en = 6'b111000;
        OP_JAL, OP_LUI, OP_AUIPC: en = 6'b100100;
        OP_JALR: en = 6'b110100;
        OP_NOP, OP_FENCE: en = 6'b100000;
        default: en = 6'b000000;
    endcase
    bubble = halt || (jump && inst != `ID_INST_NOP) || hold;
    e.inst = bubble ? `ID_INST_NOP : inst;
    if (bubble)
        en = 6'b100000;
    {e.valid, e.reg1_re, e.reg2_re, e.reg_we, e.mem_re, e.mem_we} = en;
    e.addr = addr;
    e.rs1  = inst[19:15];
    e.rs2  = inst[24:20];
    e.rd   = inst[11:7];
    return e;
endfunction

function automatic logic known_opcode(input logic [6:0] op);
    return op inside {OP_IMM, OP_REG, OP_LOAD, OP_STORE, OP_BRANCH, OP_JAL,
                      OP_JALR, OP_LUI, OP_AUIPC, OP_NOP, OP_FENCE};
endfunction

// cls 0..11: imm, reg, muldiv, load, store, branch, jal, jalr, lui, auipc, nop, fence
function automatic inst_t rand_legal(input int cls);
    inst_t w;
    funct3_t f3;
    w = $urandom();
    case (cls)
        0: w[6:0] = OP_IMM;
        1: begin
            w[6:0]   = OP_REG;
            w[31:25] = ($urandom_range(0, 1) == 1) ? F7_ALT : F7_BASE;
        end
        2: begin
            w[6:0]   = OP_REG;
            w[31:25] = F7_MULDIV;
        end
        3: begin
            f3 = 3'($urandom_range(0, 4));
            if (f3 >= 3'd3)
                f3 = f3 + 3'd1;   // skip the unused 3
            w[6:0]   = OP_LOAD;
            w[14:12] = f3;
        end
        4: begin
            w[6:0]   = OP_STORE;
            w[14:12] = 3'($urandom_range(0, 2));
        end
        5: begin
            f3 = 3'($urandom_range(0, 5));
            if (f3 >= 3'd2)
                f3 = f3 + 3'd2;
            w[6:0]   = OP_BRANCH;
            w[14:12] = f3;
        end
        6: w[6:0] = OP_JAL;
        7: w[6:0] = OP_JALR;
        8: w[6:0] = OP_LUI;
        9: w[6:0] = OP_AUIPC;
        10: w[6:0] = OP_NOP;
        default: w[6:0] = OP_FENCE;
    endcase
    return w;
endfunction

// kind 0..4: unknown opcode, bad load f3, bad store f3, bad branch f3, bad funct7
function automatic inst_t rand_illegal(input int kind);
    inst_t      w;
    logic [6:0] op;
    logic [6:0] f7;
    int         r;
    w = $urandom();
    case (kind)
        0: begin
            do op = 7'($urandom()); while (known_opcode(op));
            w[6:0] = op;
        end
        1: begin
            r = int'($urandom_range(0, 2));
            w[6:0]   = OP_LOAD;
            w[14:12] = (r == 0) ? 3'd3 : ((r == 1) ? 3'd6 : 3'd7);
        end
        2: begin
            w[6:0]   = OP_STORE;
            w[14:12] = 3'($urandom_range(3, 7));
        end
        3: begin
            w[6:0]   = OP_BRANCH;
            w[14:12] = 3'($urandom_range(2, 3));
        end
        default: begin
            do f7 = 7'($urandom()); while (f7 inside {F7_BASE, F7_ALT, F7_MULDIV});
            w[6:0]   = OP_REG;
            w[31:25] = f7;
        end
    endcase
    return w;
endfunction

`endif

/* tb_id.sv */
// testbench for id_stage, one vector per cycle, outputs checked one cycle later
// checks run at the falling edge, inputs change 1 ns after the rising edge
// stops at the first mismatch
`timescale 1ns/1ps
`include "id_defines.svh"

module tb_id;

    import id_pkg::*;

    `include "tb_id_ref.svh"

    localparam int SEED        = 32'h8c52fe5a;
    localparam int N_LEGAL     = 240;
    localparam int N_ILLEGAL   = 80;
    localparam int N_QUIRK     = 11;   // 8 muldiv + SB/SH/SW
    localparam int N_DIRECTED  = 2;
    localparam int N_BUBBLE    = 160;
    localparam int NUM_VEC     = N_LEGAL + N_ILLEGAL + N_QUIRK + N_DIRECTED + N_BUBBLE;
    localparam int WATCHDOG_NS = NUM_VEC * 10 + 200;

    logic       clk;
    logic       reset_i;
    inst_t      inst_i;
    inst_addr_t inst_addr_i;
    logic       jump_flag_i;
    logic       hold_flag_i;
    logic       halt_flag_i;
    logic       reg1_re_o;
    reg_addr_t  reg1_raddr_o;
    logic       reg2_re_o;
    reg_addr_t  reg2_raddr_o;
    logic       reg_we_o;
    reg_addr_t  reg_waddr_o;
    inst_t      inst_o;
    inst_addr_t inst_addr_o;
    logic       inst_valid_o;
    logic       mem_re_o;
    logic       mem_we_o;

    exp_t exp_q[$];
    int   checked = 0;

    id_stage i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic check_field(input string name, input logic [31:0] got,
                               input logic [31:0] want);
        assert (got === want) else begin
            $display("ERR %s got %h exp %h", name, got, want);
            $display("Something failed");
            $fatal(1, "output mismatch on %s", name);
        end
    endtask

    task automatic compare_outputs(input exp_t e);
        check_field("inst_o", inst_o, e.inst);
        check_field("inst_addr_o", inst_addr_o, e.addr);
        check_field("inst_valid_o", 32'(inst_valid_o), 32'(e.valid));
        check_field("reg1_re_o", 32'(reg1_re_o), 32'(e.reg1_re));
        check_field("reg2_re_o", 32'(reg2_re_o), 32'(e.reg2_re));
        check_field("reg_we_o", 32'(reg_we_o), 32'(e.reg_we));
        check_field("mem_re_o", 32'(mem_re_o), 32'(e.mem_re));
        check_field("mem_we_o", 32'(mem_we_o), 32'(e.mem_we));
        check_field("reg1_raddr_o", 32'(reg1_raddr_o), 32'(e.rs1));
        check_field("reg2_raddr_o", 32'(reg2_raddr_o), 32'(e.rs2));
        check_field("reg_waddr_o", 32'(reg_waddr_o), 32'(e.rd));
    endtask

    task automatic apply_vec(input inst_t inst, input inst_addr_t addr,
                             input logic jump, input logic hold, input logic halt);
        @(posedge clk);
        #1;
        inst_i      = inst;
        inst_addr_i = addr;
        jump_flag_i = jump;
        hold_flag_i = hold;
        halt_flag_i = halt;
        exp_q.push_back(expect_out(inst, addr, jump, hold, halt));
    endtask

    // compare process, the entry popped at an edge was sampled by that edge
    initial begin
        exp_t cur;
        forever begin
            @(posedge clk);
            if (exp_q.size() > 0) begin
                cur = exp_q.pop_front();
                @(negedge clk);
                compare_outputs(cur);
                checked++;
            end
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("run timed out with %0d of %0d vectors checked", checked, NUM_VEC);
        $display("Something failed");
        $fatal(1, "watchdog expired");
    end

    initial begin
        int         i;
        inst_t      w;
        logic [2:0] fl;
        void'($urandom(SEED));
        reset_i     = 1'b1;
        inst_i      = '0;
        inst_addr_i = '0;
        jump_flag_i = 1'b0;
        hold_flag_i = 1'b0;
        halt_flag_i = 1'b0;
        repeat (2) @(posedge clk);
        #1;
        reset_i = 1'b0;
        @(negedge clk);
        compare_outputs('0);   // reset values, all zero

        for (i = 0; i < N_LEGAL; i++)
            apply_vec(rand_legal(i % 12), $urandom(), 1'b0, 1'b0, 1'b0);
        for (i = 0; i < N_ILLEGAL; i++)
            apply_vec(rand_illegal(i % 5), $urandom(), 1'b0, 1'b0, 1'b0);

        for (i = 0; i < 8; i++) begin
            w = rand_legal(2);
            w[14:12] = 3'(i);   // MUL .. REMU
            apply_vec(w, $urandom(), 1'b0, 1'b0, 1'b0);
        end
        for (i = 0; i < 3; i++) begin
            w = rand_legal(4);
            w[14:12] = 3'(i);   // SB, SH, SW
            apply_vec(w, $urandom(), 1'b0, 1'b0, 1'b0);
        end

        apply_vec(`ID_INST_NOP, $urandom(), 1'b1, 1'b0, 1'b0);   // jump on NOP itself
        apply_vec(rand_legal(3), $urandom(), 1'b1, 1'b1, 1'b1);
        for (i = 0; i < N_BUBBLE; i++) begin
            fl = 3'($urandom_range(1, 7));
            w  = ($urandom_range(0, 3) == 0) ? `ID_INST_NOP : rand_legal(i % 12);
            apply_vec(w, $urandom(), fl[0], fl[1], fl[2]);
        end

        wait (checked == NUM_VEC);
        $display("Everything OK");
        $finish;
    end

endmodule
